// File: src/ks10Pkg.sv
////////////////////////////////////////////////////////////
// KS10 datapath definitions
// Word widths, microinstruction layout and bus selectors
////////////////////////////////////////////////////////////

package ks10Pkg;

   // Machine word, bit 0 is the most significant
   localparam int wordWidth = 36;
   // Half word for VMA address, flags and microcode number
   localparam int halfWidth = 18;

   // Accumulator file geometry
   localparam int acCount = 16;
   localparam int acAddrWidth = 4;

   // VMA flag positions in the left half of the VMA register
   localparam int vmaReadBit = 3;
   localparam int vmaAcRefBit = 9;

   ////////////////////////////////////////////////////////////
   // Selectors
   ////////////////////////////////////////////////////////////

   // Data-bus source
   typedef enum logic [1:0] {
      dbusFlags   = 2'd0,
      dbusDp      = 2'd1,
      dbusRamfile = 2'd2,
      dbusDbm     = 2'd3
   } dbusSelT;

   // Memory-side source
   typedef enum logic [1:0] {
      dbmMem    = 2'd0,
      dbmVma    = 2'd1,
      dbmDpSwap = 2'd2,
      dbmNumber = 2'd3
   } dbmSelT;

   // ALU operation, A is the bus and B the accumulator
   typedef enum logic [2:0] {
      aluPassA = 3'd0,
      aluAdd   = 3'd1,
      aluSub   = 3'd2,
      aluAnd   = 3'd3,
      aluOr    = 3'd4,
      aluXor   = 3'd5,
      aluPassB = 3'd6,
      aluInc   = 3'd7
   } aluOpT;

   // One microinstruction, 32 bits
   typedef struct packed {
      dbusSelT     dbusSel;
      dbmSelT      dbmSel;
      aluOpT       aluOp;
      logic [3:0]  acNum;
      logic        ramWrite;
      logic        loadVma;
      logic        vmaRead;
      logic [17:0] number;
   } cromWord;

endpackage

// File: src/dbusSrcIf.sv
////////////////////////////////////////////////////////////
// Data-bus source bundle
// Carries every candidate bus value to the bus multiplexer
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface dbusSrcIf (input logic clk);

   // Datapath sources, all valid every cycle
   logic [0:ks10Pkg::wordWidth-1] dp;
   logic [0:ks10Pkg::wordWidth-1] ramfile;
   logic [0:ks10Pkg::wordWidth-1] dbm;
   logic [0:ks10Pkg::wordWidth-1] vmaReg;
   // Flags word inputs
   logic [0:ks10Pkg::halfWidth-1] pcFlags;
   logic [0:2]                    piReqPri;

   // Driven by the top-level wiring
   modport src (output dp, ramfile, dbm, vmaReg, pcFlags, piReqPri);

   // Read by the bus multiplexer, clock only for checks
   modport mux (input clk, dp, ramfile, dbm, vmaReg, pcFlags, piReqPri);

endinterface

// File: src/vmaReg.sv
////////////////////////////////////////////////////////////
// Virtual memory address register
// Holds the address half of dp with read and AC-reference flags
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vmaReg (
   input  logic                          clk,
   input  logic                          rstN,
   input  ks10Pkg::cromWord              crom,
   input  logic [0:ks10Pkg::wordWidth-1] dp,
   output logic [0:ks10Pkg::wordWidth-1] vmaReg,
   output logic [0:ks10Pkg::halfWidth-1] vmaAddr,
   output logic                          memRead,
   output logic                          acRead
);

   // Stored address and flags
   logic [0:ks10Pkg::halfWidth-1] addrQ;
   logic                          readQ;
   logic                          acRefQ;
   logic                          acReadQ;
   // Address half of dp and its AC test
   logic [0:ks10Pkg::halfWidth-1] nextAddr;
   logic                          nextAcRef;
   logic [0:ks10Pkg::halfWidth-1] flagHalf;

   assign nextAddr = dp[ks10Pkg::halfWidth:ks10Pkg::wordWidth-1];
   // Addresses 0 to 15 land in the accumulators
   assign nextAcRef = (nextAddr < ks10Pkg::acCount);

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         addrQ   <= '0;
         readQ   <= 1'b0;
         acRefQ  <= 1'b0;
         acReadQ <= 1'b0;
      end
      else if (crom.loadVma)
      begin
         addrQ   <= nextAddr;
         readQ   <= crom.vmaRead;
         acRefQ  <= nextAcRef;
         // AC read decided once, here
         acReadQ <= crom.vmaRead & nextAcRef;
      end
   end

   // Flags packed into the left half
   always_comb
   begin
      flagHalf = '0;
      flagHalf[ks10Pkg::vmaReadBit]  = readQ;
      flagHalf[ks10Pkg::vmaAcRefBit] = acRefQ;
   end

   assign vmaReg  = {flagHalf, addrQ};
   assign vmaAddr = addrQ;
   assign memRead = readQ;
   assign acRead  = acReadQ;

   // AC read only on a stored read of an AC address
   assert property (@(posedge clk) disable iff (!rstN)
      acRead |-> (memRead && (vmaAddr < ks10Pkg::acCount)))
      else $error("acRead without a stored AC read");

endmodule

// File: src/dbmMux.sv
////////////////////////////////////////////////////////////
// Memory-side multiplexer
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dbmMux (
   input  ks10Pkg::cromWord              crom,
   input  logic [0:ks10Pkg::wordWidth-1] memData,
   input  logic [0:ks10Pkg::wordWidth-1] vmaReg,
   input  logic [0:ks10Pkg::wordWidth-1] dp,
   output logic [0:ks10Pkg::wordWidth-1] dbm
);

   // Four-way select on dbmSel
   always_comb
   begin
      case (crom.dbmSel)
         ks10Pkg::dbmMem:
            dbm = memData;
         ks10Pkg::dbmVma:
            dbm = vmaReg;
         // Halves swapped
         ks10Pkg::dbmDpSwap:
            dbm = {dp[ks10Pkg::halfWidth:ks10Pkg::wordWidth-1],
                   dp[0:ks10Pkg::halfWidth-1]};
         // Number in right half, left half zero
         ks10Pkg::dbmNumber:
            dbm = {{ks10Pkg::halfWidth{1'b0}}, crom.number};
         default:
            dbm = '0;
      endcase
   end

endmodule

// File: src/ramFile.sv
////////////////////////////////////////////////////////////
// Accumulator file
// Sixteen 36-bit accumulators written from the data bus
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ramFile (
   input  logic                          clk,
   input  logic                          rstN,
   input  ks10Pkg::cromWord              crom,
   input  logic                          acRead,
   input  logic [0:ks10Pkg::halfWidth-1] vmaAddr,
   input  logic [0:ks10Pkg::wordWidth-1] dbus,
   output logic [0:ks10Pkg::wordWidth-1] ramfile
);

   // Accumulator storage
   logic [0:ks10Pkg::wordWidth-1]   acc [0:ks10Pkg::acCount-1];
   // Selected accumulator
   logic [0:ks10Pkg::acAddrWidth-1] acSel;

   // Low VMA bits on an AC reference, else the microcode AC number
   assign acSel = acRead ?
      vmaAddr[ks10Pkg::halfWidth-ks10Pkg::acAddrWidth:ks10Pkg::halfWidth-1] :
      crom.acNum;

   // Write port
   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         for (int i = 0; i < ks10Pkg::acCount; i++)
         begin
            acc[i] <= '0;
         end
      end
      else if (crom.ramWrite)
      begin
         acc[acSel] <= dbus;
      end
   end

   // Read port, combinational
   assign ramfile = acc[acSel];

endmodule

// File: src/dbusMux.sv
////////////////////////////////////////////////////////////
// Data-bus multiplexer
// Four-way bus select with forced AC read on memory cycles
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dbusMux (
   input  ks10Pkg::cromWord              crom,
   input  logic                          acRead,
   dbusSrcIf.mux                         src,
   output logic [0:ks10Pkg::wordWidth-1] dbus
);

   logic                          forceRamfile;
   logic [0:ks10Pkg::wordWidth-1] flagsWord;

   // Memory read of an AC goes to the accumulator file
   assign forceRamfile = acRead && (crom.dbmSel == ks10Pkg::dbmMem);

   // PC flags, zero, PI priority, four ones, low VMA bits
   assign flagsWord = {src.pcFlags, 1'b0, src.piReqPri, 4'b1111,
                       src.vmaReg[26:35]};

   ////////////////////////////////////////////////////////////
   // Bus select
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      case (crom.dbusSel)
         ks10Pkg::dbusFlags:
            dbus = flagsWord;
         ks10Pkg::dbusDp:
            dbus = src.dp;
         ks10Pkg::dbusRamfile:
            dbus = src.ramfile;
         ks10Pkg::dbusDbm:
            dbus = forceRamfile ? src.ramfile : src.dbm;
         default:
            dbus = '0;
      endcase
   end

   // AC-referenced memory read must never reach the bus from dbm
   assert property (@(posedge src.clk)
      ((crom.dbusSel == ks10Pkg::dbusDbm) && (crom.dbmSel == ks10Pkg::dbmMem) && acRead)
      |-> (dbus == src.ramfile))
      else $error("forced accumulator read not on dbus");

endmodule

// File: src/aluUnit.sv
////////////////////////////////////////////////////////////
// ALU and datapath output register
// Combines the bus and an accumulator, registers the result
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module aluUnit (
   input  logic                          clk,
   input  logic                          rstN,
   input  ks10Pkg::cromWord              crom,
   input  logic [0:ks10Pkg::wordWidth-1] dbus,
   input  logic [0:ks10Pkg::wordWidth-1] ramfile,
   output logic [0:ks10Pkg::wordWidth-1] dp
);

   // Operands, A from the bus and B from the AC file
   logic [0:ks10Pkg::wordWidth-1] opA;
   logic [0:ks10Pkg::wordWidth-1] opB;
   logic [0:ks10Pkg::wordWidth-1] result;

   assign opA = dbus;
   assign opB = ramfile;

   ////////////////////////////////////////////////////////////
   // Function select
   ////////////////////////////////////////////////////////////

   // Sums wrap at 36 bits
   always_comb
   begin
      case (crom.aluOp)
         ks10Pkg::aluPassA:
            result = opA;
         ks10Pkg::aluAdd:
            result = opA + opB;
         ks10Pkg::aluSub:
            result = opA - opB;
         ks10Pkg::aluAnd:
            result = opA & opB;
         ks10Pkg::aluOr:
            result = opA | opB;
         ks10Pkg::aluXor:
            result = opA ^ opB;
         ks10Pkg::aluPassB:
            result = opB;
         ks10Pkg::aluInc:
            result = opA + 1'b1;
         default:
            result = '0;
      endcase
   end

   // Output register, loads every clock
   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         dp <= '0;
      end
      else
      begin
         dp <= result;
      end
   end

   // Datapath comes out of reset clear
   assert property (@(posedge clk) !rstN |=> (dp == '0))
      else $error("dp not cleared by reset");

endmodule

// File: src/dataPath.sv
////////////////////////////////////////////////////////////
// KS10 data-bus datapath, top level
// Connects VMA, memory mux, AC file, bus mux and ALU
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dataPath (
   input  logic                          clk,
   input  logic                          rstN,
   input  ks10Pkg::cromWord              crom,
   input  logic [0:ks10Pkg::wordWidth-1] memData,
   input  logic [0:ks10Pkg::halfWidth-1] pcFlags,
   input  logic [0:2]                    piReqPri,
   output logic [0:ks10Pkg::wordWidth-1] dbus,
   output logic [0:ks10Pkg::wordWidth-1] dp,
   output logic [0:ks10Pkg::halfWidth-1] vmaAddr,
   output logic                          memRead
);

   // AC reference on a read, from the VMA
   logic acRead;

   // Bus sources
   dbusSrcIf busSrc (.clk(clk));

   assign busSrc.dp       = dp;
   assign busSrc.pcFlags  = pcFlags;
   assign busSrc.piReqPri = piReqPri;

   ////////////////////////////////////////////////////////////
   // Blocks
   ////////////////////////////////////////////////////////////

   vmaReg uVma (
      .clk(clk), .rstN(rstN), .crom(crom), .dp(dp),
      .vmaReg(busSrc.vmaReg), .vmaAddr(vmaAddr),
      .memRead(memRead), .acRead(acRead)
   );

   dbmMux uDbm (
      .crom(crom), .memData(memData), .vmaReg(busSrc.vmaReg),
      .dp(dp), .dbm(busSrc.dbm)
   );

   ramFile uRam (
      .clk(clk), .rstN(rstN), .crom(crom), .acRead(acRead),
      .vmaAddr(vmaAddr), .dbus(dbus), .ramfile(busSrc.ramfile)
   );

   dbusMux uDbus (
      .crom(crom), .acRead(acRead), .src(busSrc.mux), .dbus(dbus)
   );

   aluUnit uAlu (
      .clk(clk), .rstN(rstN), .crom(crom), .dbus(dbus),
      .ramfile(busSrc.ramfile), .dp(dp)
   );

endmodule

// File: sim/clockGen.sv
////////////////////////////////////////////////////////////
// Testbench clock and reset
// 20 ns clock, synchronous reset held low at start
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module clockGen #(
   parameter int resetCycles = 10
) (
   output logic clk,
   output logic rstN
);

   localparam int halfPeriod = 10;

   initial
   begin
      clk = 1'b0;
      forever #halfPeriod clk = ~clk;
   end

   // Release on a falling edge, away from the sampling edge
   initial
   begin
      rstN = 1'b0;
      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;
   end

endmodule

// File: sim/dataPathChecker.sv
////////////////////////////////////////////////////////////
// Datapath checker
// Compares bus, dp, memRead and VMA address against the current row
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dataPathChecker #(
   parameter int nameBytes = 12
) (
   input  logic                          clk,
   input  logic                          rowValid,
   input  logic [8*nameBytes-1:0]        rowName,
   input  logic [0:ks10Pkg::wordWidth-1] expDbus,
   input  logic [0:ks10Pkg::wordWidth-1] expDp,
   input  logic                          expMemRead,
   input  logic [0:ks10Pkg::halfWidth-1] expVmaAddr,
   input  logic [0:ks10Pkg::wordWidth-1] dbus,
   input  logic [0:ks10Pkg::wordWidth-1] dp,
   input  logic                          memRead,
   input  logic [0:ks10Pkg::halfWidth-1] vmaAddr,
   output int                            checkedCount,
   output int                            passCount,
   output int                            failCount
);

   // Values seen around the edge
   logic [0:ks10Pkg::wordWidth-1] busSeen;
   logic [0:ks10Pkg::wordWidth-1] dpSeen;
   logic                          readSeen;
   logic [0:ks10Pkg::halfWidth-1] vmaSeen;
   int                            errors;
   // Running totals
   int checks = 0;
   int passes = 0;
   int fails = 0;

   assign checkedCount = checks;
   assign passCount    = passes;
   assign failCount    = fails;

   always @(posedge clk)
   begin
      if (rowValid)
      begin
         // Bus, memRead and VMA address still hold the pre-edge cycle here
         busSeen  = dbus;
         readSeen = memRead;
         vmaSeen  = vmaAddr;
         // dp settles once the register has loaded
         #1;
         dpSeen = dp;
         errors = 0;
         if (busSeen !== expDbus)
         begin
            $display("Fail %0s dbus expected %h actual %h", rowName, expDbus, busSeen);
            errors++;
         end
         if (dpSeen !== expDp)
         begin
            $display("Fail %0s dp expected %h actual %h", rowName, expDp, dpSeen);
            errors++;
         end
         if (readSeen !== expMemRead)
         begin
            $display("Fail %0s memRead expected %b actual %b", rowName, expMemRead, readSeen);
            errors++;
         end
         if (vmaSeen !== expVmaAddr)
         begin
            $display("Fail %0s vmaAddr expected %h actual %h", rowName, expVmaAddr, vmaSeen);
            errors++;
         end
         if (errors == 0)
         begin
            $display("Pass %0s", rowName);
            passes++;
         end
         else
         begin
            fails++;
         end
         checks++;
      end
   end

endmodule

// File: sim/dataPathTb.sv
////////////////////////////////////////////////////////////
// Datapath testbench
// Applies a table of control words and expected bus values
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dataPathTb;

   localparam int resetCycles = 10;
   localparam int rowCount = 25;
   localparam int nameBytes = 12;
   // Rows, reset and some slack
   localparam int cycleLimit = rowCount + resetCycles + 20;

   logic                          clk;
   logic                          rstN;
   ks10Pkg::cromWord              crom;
   logic [0:ks10Pkg::wordWidth-1] memData;
   logic [0:ks10Pkg::halfWidth-1] pcFlags;
   logic [0:2]                    piReqPri;
   logic [0:ks10Pkg::wordWidth-1] dbus;
   logic [0:ks10Pkg::wordWidth-1] dp;
   logic [0:ks10Pkg::halfWidth-1] vmaAddr;
   logic                          memRead;
   // Current row for the checker
   logic                          rowValid;
   logic [8*nameBytes-1:0]        rowName;
   logic [0:ks10Pkg::wordWidth-1] expDbus;
   logic [0:ks10Pkg::wordWidth-1] expDp;
   logic                          expMemRead;
   logic [0:ks10Pkg::halfWidth-1] expVmaAddr;
   int                            checkedCount;
   int                            passCount;
   int                            failCount;
   int                            cycles;
   int                            rowFill = 0;

   ////////////////////////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////////////////////////

   logic [8*nameBytes-1:0]        nameTab [0:rowCount-1];
   ks10Pkg::cromWord              cromTab [0:rowCount-1];
   logic [0:ks10Pkg::wordWidth-1] memTab [0:rowCount-1];
   logic [0:ks10Pkg::halfWidth-1] flagsTab [0:rowCount-1];
   logic [0:2]                    priTab [0:rowCount-1];
   logic [0:ks10Pkg::wordWidth-1] busTab [0:rowCount-1];
   logic [0:ks10Pkg::wordWidth-1] dpTab [0:rowCount-1];
   logic                          readTab [0:rowCount-1];
   logic [0:ks10Pkg::halfWidth-1] vmaTab [0:rowCount-1];

   clockGen #(.resetCycles(resetCycles)) clkGen (.clk(clk), .rstN(rstN));

   dataPath uut (
      .clk(clk), .rstN(rstN), .crom(crom), .memData(memData),
      .pcFlags(pcFlags), .piReqPri(piReqPri), .dbus(dbus), .dp(dp),
      .vmaAddr(vmaAddr), .memRead(memRead)
   );

   dataPathChecker #(.nameBytes(nameBytes)) chk (
      .clk(clk), .rowValid(rowValid), .rowName(rowName), .expDbus(expDbus),
      .expDp(expDp), .expMemRead(expMemRead), .expVmaAddr(expVmaAddr),
      .dbus(dbus), .dp(dp), .memRead(memRead), .vmaAddr(vmaAddr),
      .checkedCount(checkedCount), .passCount(passCount), .failCount(failCount)
   );

   // ctl is {ramWrite, loadVma, vmaRead}
   function automatic ks10Pkg::cromWord makeCrom(input ks10Pkg::dbusSelT busSel,
      input ks10Pkg::dbmSelT memSel, input ks10Pkg::aluOpT op, input logic [3:0] ac,
      input logic [2:0] ctl, input logic [17:0] num);
      ks10Pkg::cromWord w;
      w.dbusSel  = busSel;
      w.dbmSel   = memSel;
      w.aluOp    = op;
      w.acNum    = ac;
      w.ramWrite = ctl[2];
      w.loadVma  = ctl[1];
      w.vmaRead  = ctl[0];
      w.number   = num;
      return w;
   endfunction

   task automatic addRow(input logic [8*nameBytes-1:0] name, input ks10Pkg::cromWord c,
      input logic [0:35] mem, input logic [0:17] flags, input logic [0:2] pri,
      input logic [0:35] bus, input logic [0:35] dpVal, input logic rd,
      input logic [0:17] vma);
      nameTab[rowFill]  = name;
      cromTab[rowFill]  = c;
      memTab[rowFill]   = mem;
      flagsTab[rowFill] = flags;
      priTab[rowFill]   = pri;
      busTab[rowFill]   = bus;
      dpTab[rowFill]    = dpVal;
      readTab[rowFill]  = rd;
      vmaTab[rowFill]   = vma;
      rowFill++;
   endtask

   // B operand in the ALU rows is AC1 = 12345
   // Last two columns are memRead and VMA address before the edge
   task automatic fillTable();
      addRow("reset", makeCrom(ks10Pkg::dbusDp, ks10Pkg::dbmMem, ks10Pkg::aluPassA, 0, 3'b000, 0),
         36'h0, 0, 0, 36'h000000000, 36'h000000000, 0, 18'h0);
      addRow("loadAc1", makeCrom(ks10Pkg::dbusDbm, ks10Pkg::dbmNumber, ks10Pkg::aluPassA, 1,
         3'b100, 18'h12345), 36'h0, 0, 0, 36'h000012345, 36'h000012345, 0, 18'h0);
      addRow("aluPassA", makeCrom(ks10Pkg::dbusDbm, ks10Pkg::dbmMem, ks10Pkg::aluPassA, 1,
         3'b000, 0), 36'h123456789, 0, 0, 36'h123456789, 36'h123456789, 0, 18'h0);
      // Sum wraps past 36 bits
      addRow("aluAdd", makeCrom(ks10Pkg::dbusDbm, ks10Pkg::dbmMem, ks10Pkg::aluAdd, 1, 3'b000, 0),
         36'hfffffffff, 0, 0, 36'hfffffffff, 36'h000012344, 0, 18'h0);
      addRow("aluSub", makeCrom(ks10Pkg::dbusDbm, ks10Pkg::dbmMem, ks10Pkg::aluSub, 1, 3'b000, 0),
         36'h000010000, 0, 0, 36'h000010000, 36'hfffffdcbb, 0, 18'h0);
      addRow("aluAnd", makeCrom(ks10Pkg::dbusDbm, ks10Pkg::dbmMem, ks10Pkg::aluAnd, 1, 3'b000, 0),
         36'h0000ff0f0, 0, 0, 36'h0000ff0f0, 36'h000012040, 0, 18'h0);
      // Overlapping bits keep OR apart from XOR and ADD
      addRow("aluOr", makeCrom(ks10Pkg::dbusDbm, ks10Pkg::dbmMem, ks10Pkg::aluOr, 1, 3'b000, 0),
         36'ha0000ff00, 0, 0, 36'ha0000ff00, 36'ha0001ff45, 0, 18'h0);
      addRow("aluXor", makeCrom(ks10Pkg::dbusDbm, ks10Pkg::dbmMem, ks10Pkg::aluXor, 1, 3'b000, 0),
         36'h0000fffff, 0, 0, 36'h0000fffff, 36'h0000edcba, 0, 18'h0);
      addRow("aluPassB", makeCrom(ks10Pkg::dbusDbm, ks10Pkg::dbmMem, ks10Pkg::aluPassB, 1,
         3'b000, 0), 36'h555555555, 0, 0, 36'h555555555, 36'h000012345, 0, 18'h0);
      addRow("aluInc", makeCrom(ks10Pkg::dbusDbm, ks10Pkg::dbmMem, ks10Pkg::aluInc, 1, 3'b000, 0),
         36'hfffffffff, 0, 0, 36'hfffffffff, 36'h000000000, 0, 18'h0);
      // Accumulator file
      addRow("loadAc7", makeCrom(ks10Pkg::dbusDbm, ks10Pkg::dbmMem, ks10Pkg::aluPassA, 7, 3'b100, 0),
         36'hdeadbeef1, 0, 0, 36'hdeadbeef1, 36'hdeadbeef1, 0, 18'h0);
      addRow("readAc7", makeCrom(ks10Pkg::dbusRamfile, ks10Pkg::dbmMem, ks10Pkg::aluPassA, 7,
         3'b000, 0), 36'h0, 0, 0, 36'hdeadbeef1, 36'hdeadbeef1, 0, 18'h0);
      addRow("readAc1", makeCrom(ks10Pkg::dbusRamfile, ks10Pkg::dbmMem, ks10Pkg::aluPassA, 1,
         3'b000, 0), 36'h0, 0, 0, 36'h000012345, 36'h000012345, 0, 18'h0);
      addRow("readAc3", makeCrom(ks10Pkg::dbusRamfile, ks10Pkg::dbmMem, ks10Pkg::aluPassA, 3,
         3'b000, 0), 36'h0, 0, 0, 36'h000000000, 36'h000000000, 0, 18'h0);
      // Flags word with VMA still zero
      addRow("flags", makeCrom(ks10Pkg::dbusFlags, ks10Pkg::dbmMem, ks10Pkg::aluPassA, 0,
         3'b000, 0), 36'h0, 18'h2aaaa, 3'd5, 36'haaaa97c00, 36'haaaa97c00, 0, 18'h0);
      // AC5 = 5 and dp = 5, then a read of address 5
      addRow("loadAc5", makeCrom(ks10Pkg::dbusDbm, ks10Pkg::dbmNumber, ks10Pkg::aluPassA, 5,
         3'b100, 18'h5), 36'h0, 0, 0, 36'h000000005, 36'h000000005, 0, 18'h0);
      addRow("loadVma5", makeCrom(ks10Pkg::dbusDp, ks10Pkg::dbmMem, ks10Pkg::aluPassA, 0,
         3'b011, 0), 36'h0, 0, 0, 36'h000000005, 36'h000000005, 0, 18'h0);
      addRow("acForce5", makeCrom(ks10Pkg::dbusDbm, ks10Pkg::dbmMem, ks10Pkg::aluPassA, 0,
         3'b000, 0), 36'h777777777, 0, 0, 36'h000000005, 36'h000000005, 1, 18'h5);
      // Address 20 is memory, not an AC
      addRow("setDp20", makeCrom(ks10Pkg::dbusDbm, ks10Pkg::dbmNumber, ks10Pkg::aluPassA, 0,
         3'b000, 18'd20), 36'h0, 0, 0, 36'h000000014, 36'h000000014, 1, 18'h5);
      addRow("loadVma20", makeCrom(ks10Pkg::dbusDp, ks10Pkg::dbmMem, ks10Pkg::aluPassA, 0,
         3'b011, 0), 36'h0, 0, 0, 36'h000000014, 36'h000000014, 1, 18'h5);
      addRow("memRead20", makeCrom(ks10Pkg::dbusDbm, ks10Pkg::dbmMem, ks10Pkg::aluPassA, 0,
         3'b000, 0), 36'h777777777, 0, 0, 36'h777777777, 36'h777777777, 1, 18'h14);
      // Read flag sits at left-half bit 3
      addRow("dbmVma", makeCrom(ks10Pkg::dbusDbm, ks10Pkg::dbmVma, ks10Pkg::aluPassA, 0, 3'b000, 0),
         36'h0, 0, 0, 36'h100000014, 36'h100000014, 1, 18'h14);
      addRow("dbmDpSwap", makeCrom(ks10Pkg::dbusDbm, ks10Pkg::dbmDpSwap, ks10Pkg::aluPassA, 0,
         3'b000, 0), 36'h0, 0, 0, 36'h000504000, 36'h000504000, 1, 18'h14);
      addRow("dbmNumber", makeCrom(ks10Pkg::dbusDbm, ks10Pkg::dbmNumber, ks10Pkg::aluPassA, 0,
         3'b000, 18'h2beef), 36'h0, 0, 0, 36'h00002beef, 36'h00002beef, 1, 18'h14);
      addRow("flagsVma", makeCrom(ks10Pkg::dbusFlags, ks10Pkg::dbmMem, ks10Pkg::aluPassA, 0,
         3'b000, 0), 36'h0, 18'h00001, 3'd7, 36'h00005fc14, 36'h00005fc14, 1, 18'h14);
   endtask

   task automatic applyRow(input int i);
      crom       = cromTab[i];
      memData    = memTab[i];
      pcFlags    = flagsTab[i];
      piReqPri   = priTab[i];
      rowName    = nameTab[i];
      expDbus    = busTab[i];
      expDp      = dpTab[i];
      expMemRead = readTab[i];
      expVmaAddr = vmaTab[i];
      rowValid   = 1'b1;
   endtask

   initial
   begin
      // Idle word recirculates dp so it stays clear after reset
      crom = makeCrom(ks10Pkg::dbusDp, ks10Pkg::dbmMem, ks10Pkg::aluPassA, 0, 3'b000, 0);
      memData    = '0;
      pcFlags    = '0;
      piReqPri   = '0;
      rowValid   = 1'b0;
      rowName    = '0;
      expDbus    = '0;
      expDp      = '0;
      expMemRead = 1'b0;
      expVmaAddr = '0;
      fillTable();
      wait (rstN === 1'b1);
      for (int i = 0; i < rowCount; i++)
      begin
         @(negedge clk);
         applyRow(i);
      end
      @(negedge clk);
      rowValid = 1'b0;
      wait (checkedCount == rowCount);
      $display("Rows checked %0d, passed %0d, failed %0d", checkedCount, passCount, failCount);
      if (failCount == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

   // Watchdog
   initial
   begin
      cycles = 0;
      while (cycles < cycleLimit)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("Run timed out after %0d cycles with %0d of %0d rows checked",
         cycles, checkedCount, rowCount);
      $display("Test failures found");
      $finish;
   end

endmodule

// File: sim.f
src/ks10Pkg.sv
src/dbusSrcIf.sv
src/vmaReg.sv
src/dbmMux.sv
src/ramFile.sv
src/dbusMux.sv
src/aluUnit.sv
src/dataPath.sv
sim/clockGen.sv
sim/dataPathChecker.sv
sim/dataPathTb.sv

// File: Bender.yml
package:
  name: ks10datapath

sources:
  - src/ks10Pkg.sv
  - src/dbusSrcIf.sv
  - src/vmaReg.sv
  - src/dbmMux.sv
  - src/ramFile.sv
  - src/dbusMux.sv
  - src/aluUnit.sv
  - src/dataPath.sv
  - target: test
    files:
      - sim/clockGen.sv
      - sim/dataPathChecker.sv
      - sim/dataPathTb.sv
